// File: tb.f
+incdir+.
l1_pkg.sv
l1_tag_array.sv
l1_state_array.sv
l1_data_array.sv
l1_mempipe.sv
l1_cdiff.sv
l1_top.sv
tb_l1_props.sv
tb_l1.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_l1
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_l1.sv
`default_nettype none

`include "l1_params.svh"

module tb_l1;

    localparam int SET_W          = $clog2(`L1_NUM_SETS);
    localparam int NUM_REQS       = 80;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 8 + 200;
    localparam int RESP_LAT       = 2;

    typedef struct {
        int unsigned           acc_cyc;
        l1_pkg::t_mempipe_resp rsp;
        logic                  chk_way;
        logic                  chk_data;
    } t_exp_resp;

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    logic                  req_ready;
    l1_pkg::t_mempipe_req  req;
    logic                  resp_valid;
    l1_pkg::t_mempipe_resp resp;
    logic                  diff_valid;
    logic                  diff_ready = 1'b0;
    l1_pkg::t_diff_rec     diff;

    logic                  bp_en;
    int unsigned           cycle = 0;
    int unsigned           errors = 0;
    int unsigned           checks = 0;
    int unsigned           stalls = 0;
    int unsigned           err_mark;
    int unsigned           stall_mark;
    t_exp_resp             resp_q[$];
    l1_pkg::t_diff_rec     diff_q[$];

    // reference copy of the cache contents
    l1_pkg::t_l1_tag       m_tag   [`L1_NUM_SETS][`L1_NUM_WAYS];
    l1_pkg::t_mesi         m_state [`L1_NUM_SETS][`L1_NUM_WAYS];
    l1_pkg::t_cl           m_data  [`L1_NUM_SETS][`L1_NUM_WAYS];
    l1_pkg::t_l1_way       m_victim[`L1_NUM_SETS];

    l1_top l1_top_inst (
        .clk, .reset, .req_valid, .req_ready, .req, .resp_valid, .resp,
        .diff_valid, .diff_ready, .diff
    );

    bind l1_mempipe tb_l1_props props_inst (
        .clk, .reset, .accept, .rd_set, .req_ready, .resp_valid,
        .tag_wr_en, .state_wr_en, .data_wr_en, .victim_upd, .wr_way, .hit_ways
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // random back-pressure on the change log while enabled
    always @(posedge clk) begin
        if (!reset) begin
            diff_ready <= 1'b0;
        end else if (bp_en) begin
            diff_ready <= ($urandom_range(0, 9) < 4);
        end else begin
            diff_ready <= 1'b1;
        end
    end

    // **************************************************
    // reference model
    // **************************************************

    function automatic void clear_model();
        for (int s = 0; s < `L1_NUM_SETS; s++) begin
            m_victim[s] = 1'b0;
            for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_state[s][w] = l1_pkg::MESI_I;
                m_data[s][w]  = '0;
            end
        end
    endfunction

    function automatic void model_apply(
        input  l1_pkg::t_mempipe_req  r,
        output l1_pkg::t_mempipe_resp rsp,
        output logic                  chk_way,
        output logic                  chk_data,
        output logic                  has_rec,
        output l1_pkg::t_diff_rec     rec
    );
        l1_pkg::t_l1_set set;
        l1_pkg::t_l1_tag tag;
        l1_pkg::t_mesi   fill_st;
        l1_pkg::t_l1_way way;
        logic            hit;

        set     = r.paddr[SET_W-1:0];
        tag     = r.paddr[SET_W +: `L1_TAG_W];
        fill_st = r.fill_shared ? l1_pkg::MESI_S : l1_pkg::MESI_E;
        hit     = 1'b1;
        if (m_state[set][0] != l1_pkg::MESI_I && m_tag[set][0] == tag) begin
            way = 1'b0;
        end else if (m_state[set][1] != l1_pkg::MESI_I && m_tag[set][1] == tag) begin
            way = 1'b1;
        end else begin
            hit = 1'b0;
            way = 1'b0;
        end
        // a miss allocates for everything but INV
        if (!hit && r.op != l1_pkg::OP_INV) begin
            if (m_state[set][0] == l1_pkg::MESI_I) begin
                way = 1'b0;
            end else if (m_state[set][1] == l1_pkg::MESI_I) begin
                way = 1'b1;
            end else begin
                way           = m_victim[set];
                m_victim[set] = !m_victim[set];
            end
            m_tag[set][way] = tag;
        end
        has_rec  = 1'b1;
        chk_way  = 1'b1;
        chk_data = 1'b1;
        case (r.op)
            l1_pkg::OP_RD: begin
                if (hit) begin
                    has_rec = 1'b0;
                end else begin
                    m_state[set][way] = fill_st;
                    m_data[set][way]  = r.fill_data;
                end
            end
            l1_pkg::OP_WR: begin
                m_state[set][way] = l1_pkg::MESI_M;
                m_data[set][way]  = r.wr_data;
            end
            l1_pkg::OP_FILL: begin
                m_state[set][way] = fill_st;
                m_data[set][way]  = r.fill_data;
            end
            default: begin
                chk_data = 1'b0;
                if (hit) begin
                    m_state[set][way] = l1_pkg::MESI_I;  // tag and data kept
                end else begin
                    has_rec = 1'b0;
                    chk_way = 1'b0;
                end
            end
        endcase
        rsp.op      = r.op;
        rsp.hit     = hit;
        rsp.way     = way;
        rsp.rd_data = m_data[set][way];
        rec.set     = set;
        rec.way     = way;
        rec.tag     = m_tag[set][way];
        rec.state   = m_state[set][way];
        rec.data    = m_data[set][way];
        rec.op      = r.op;
    endfunction

    // **************************************************
    // comparison
    // **************************************************

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %s expected 0x%0h got 0x%0h at cycle %0d", name, exp, got, cycle);
            errors++;
        end
    endtask

    task automatic check_resp(input t_exp_resp e);
        compare_field("resp.op", 64'(resp.op), 64'(e.rsp.op));
        compare_field("resp.hit", 64'(resp.hit), 64'(e.rsp.hit));
        if (e.chk_way) compare_field("resp.way", 64'(resp.way), 64'(e.rsp.way));
        if (e.chk_data) compare_field("resp.rd_data", 64'(resp.rd_data), 64'(e.rsp.rd_data));
    endtask

    task automatic check_diff(input l1_pkg::t_diff_rec d);
        compare_field("diff.set", 64'(diff.set), 64'(d.set));
        compare_field("diff.way", 64'(diff.way), 64'(d.way));
        compare_field("diff.tag", 64'(diff.tag), 64'(d.tag));
        compare_field("diff.state", 64'(diff.state), 64'(d.state));
        compare_field("diff.data", 64'(diff.data), 64'(d.data));
        compare_field("diff.op", 64'(diff.op), 64'(d.op));
    endtask

    always @(posedge clk) begin
        t_exp_resp         e;
        l1_pkg::t_diff_rec d;
        logic              has_rec;

        if (!reset) begin
            clear_model();
            if (cycle >= 1) begin
                compare_field("req_ready", 64'(req_ready), 64'(0));
                compare_field("resp_valid", 64'(resp_valid), 64'(0));
                compare_field("diff_valid", 64'(diff_valid), 64'(0));
            end
        end else begin
            if (req_valid && req_ready) begin
                model_apply(req, e.rsp, e.chk_way, e.chk_data, has_rec, d);
                e.acc_cyc = cycle;
                resp_q.push_back(e);
                if (has_rec) diff_q.push_back(d);
            end
            if (req_valid && !req_ready) stalls++;
            // raised on edge acc+2, sampled on the edge after
            if (resp_q.size() != 0 && cycle == resp_q[0].acc_cyc + RESP_LAT + 1) begin
                e = resp_q.pop_front();
                assert (resp_valid) else begin
                    $display("response missing %0d cycles after acceptance", RESP_LAT);
                    errors++;
                end
                if (resp_valid) check_resp(e);
            end else begin
                assert (!resp_valid) else begin
                    $display("response at cycle %0d with no request due", cycle);
                    errors++;
                end
            end
            if (diff_valid && diff_ready) begin
                assert (diff_q.size() != 0) else begin
                    $display("change record at cycle %0d with none expected", cycle);
                    errors++;
                end
                if (diff_q.size() != 0) check_diff(diff_q.pop_front());
            end
        end
    end

    // **************************************************
    // stimulus
    // **************************************************

    function automatic int unsigned total_errors();
        return errors + l1_top_inst.mempipe_inst.props_inst.fail_cnt;
    endfunction

    function automatic l1_pkg::t_mempipe_req make_req(input l1_pkg::t_req_op op,
                                                      input l1_pkg::t_l1_tag tag,
                                                      input l1_pkg::t_l1_set set);
        l1_pkg::t_mempipe_req r;

        r.op          = op;
        r.paddr       = {tag, set};
        r.wr_data     = $urandom();
        r.fill_data   = $urandom();
        r.fill_shared = 1'($urandom_range(0, 1));
        return r;
    endfunction

    // returns on the edge that accepted the request
    task automatic issue(input l1_pkg::t_req_op op, input int tag, input int set);
        req_valid <= 1'b1;
        req       <= make_req(op, l1_pkg::t_l1_tag'(tag), l1_pkg::t_l1_set'(set));
        @(posedge clk);
        while (!req_ready) @(posedge clk);
    endtask

    task automatic finish_test(input int num, input string name);
        int unsigned errs;

        req_valid <= 1'b0;
        @(posedge clk);
        while (resp_q.size() != 0 || diff_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        errs = total_errors() - err_mark;
        $display("test %0d %s: %s, %0d errors, %0d stall cycles", num, name,
                 (errs == 0) ? "ok" : "FAIL", errs, stalls - stall_mark);
        err_mark   = total_errors();
        stall_mark = stalls;
    endtask

    initial begin
        int unsigned total;

        void'($urandom(81));
        reset      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        bp_en      = 1'b0;
        err_mark   = 0;
        stall_mark = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);

        for (int s = 0; s < `L1_NUM_SETS; s++) issue(l1_pkg::OP_RD, 'h10 + s, s);
        finish_test(1, "read miss allocate");

        for (int s = 0; s < 4; s++) issue(l1_pkg::OP_WR, 'h10 + s, s);
        for (int s = 0; s < 4; s++) issue(l1_pkg::OP_RD, 'h10 + s, s);
        finish_test(2, "write hit then read");

        // set 5 already holds tag 0x15 in way 0
        issue(l1_pkg::OP_RD, 'h51, 5);
        issue(l1_pkg::OP_RD, 'h52, 5);
        issue(l1_pkg::OP_RD, 'h53, 5);
        issue(l1_pkg::OP_RD, 'h15, 5);
        finish_test(3, "victim replacement");

        issue(l1_pkg::OP_INV, 'h17, 7);
        issue(l1_pkg::OP_INV, 'hEE, 8);
        issue(l1_pkg::OP_FILL, 'h19, 9);
        issue(l1_pkg::OP_RD, 'h19, 9);
        issue(l1_pkg::OP_RD, 'h17, 7);
        issue(l1_pkg::OP_FILL, 'hF0, 10);
        finish_test(4, "invalidate and fill");

        issue(l1_pkg::OP_WR, 'h1B, 11);
        issue(l1_pkg::OP_RD, 'h1B, 11);
        issue(l1_pkg::OP_WR, 'h1B, 11);
        issue(l1_pkg::OP_RD, 'h1B, 11);
        issue(l1_pkg::OP_INV, 'h1B, 11);
        issue(l1_pkg::OP_RD, 'h1B, 11);
        finish_test(5, "same-set back-to-back");

        bp_en <= 1'b1;
        for (int i = 0; i < 40; i++) begin
            issue(l1_pkg::t_req_op'(2'($urandom_range(0, 3))), 'hA0 + $urandom_range(0, 3),
                  $urandom_range(0, 3));
        end
        bp_en <= 1'b0;
        finish_test(6, "change log back-pressure");

        total = total_errors();
        $display("summary: %0d checks, %0d errors", checks, total);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, requests or records still outstanding", cycle);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_l1_props.sv
`default_nettype none

module tb_l1_props (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    accept,
    input  l1_pkg::t_l1_set         rd_set,
    input  logic                    req_ready,
    input  logic                    resp_valid,
    input  logic                    tag_wr_en,
    input  logic                    state_wr_en,
    input  logic                    data_wr_en,
    input  logic                    victim_upd,
    input  l1_pkg::t_l1_way         wr_way,
    input  logic [1:0]              hit_ways
);

    int unsigned fail_cnt = 0;

    // resp_valid is registered on the second edge after acceptance, seen one sample later
    resp_latency: assert property (@(posedge clk) disable iff (!reset)
        resp_valid == $past(accept, 3))
        else begin
            $error("resp_valid does not follow request acceptance by 2 cycles");
            fail_cnt++;
        end

    // read-after-write hazard on the set still in mm1
    same_set_stall: assert property (@(posedge clk) disable iff (!reset)
        ($past(accept) && (rd_set == $past(rd_set))) |-> !req_ready)
        else begin
            $error("req_ready high in the cycle after a same-set acceptance");
            fail_cnt++;
        end

    // a write targets one known way, never a tag held in both ways
    single_way_write: assert property (@(posedge clk) disable iff (!reset)
        (tag_wr_en || state_wr_en || data_wr_en || victim_upd)
            |-> ($onehot0(hit_ways) && !$isunknown(wr_way)))
        else begin
            $error("array write with the tag matching more than one way");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: l1_top.sv
`default_nettype none

`include "l1_params.svh"

module l1_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  l1_pkg::t_mempipe_req    req,
    output logic                    resp_valid,
    output l1_pkg::t_mempipe_resp   resp,
    output logic                    diff_valid,
    input  logic                    diff_ready,
    output l1_pkg::t_diff_rec       diff
);

    logic                               rd_en;
    l1_pkg::t_l1_set                    rd_set;
    l1_pkg::t_l1_tag [`L1_NUM_WAYS-1:0] tag_rd;
    l1_pkg::t_mesi   [`L1_NUM_WAYS-1:0] state_rd;
    l1_pkg::t_cl     [`L1_NUM_WAYS-1:0] data_rd;
    l1_pkg::t_l1_way                    victim;
    logic                               tag_wr_en;
    logic                               state_wr_en;
    logic                               data_wr_en;
    logic                               victim_upd;
    l1_pkg::t_l1_set                    wr_set;
    l1_pkg::t_l1_way                    wr_way;
    l1_pkg::t_l1_tag                    wr_tag;
    l1_pkg::t_mesi                      wr_state;
    l1_pkg::t_cl                        wr_data;
    l1_pkg::t_req_op                    wr_op;
    logic                               diff_afull;

    // **************************************************
    // pipeline control
    // **************************************************

    l1_mempipe mempipe_inst (
        .clk, .reset, .req_valid, .req_ready, .req, .resp_valid, .resp,
        .rd_en, .rd_set, .tag_rd, .state_rd, .data_rd, .victim,
        .tag_wr_en, .state_wr_en, .data_wr_en, .victim_upd,
        .wr_set, .wr_way, .wr_tag, .wr_state, .wr_data, .wr_op, .diff_afull
    );

    // **************************************************
    // arrays and change log
    // **************************************************

    l1_tag_array tag_inst (
        .clk, .rd_en, .rd_set, .wr_en(tag_wr_en), .wr_set, .wr_way, .wr_tag,
        .rd_tags(tag_rd)
    );

    l1_state_array state_inst (
        .clk, .reset, .rd_en, .rd_set, .wr_en(state_wr_en), .wr_set, .wr_way, .wr_state,
        .victim_upd, .rd_states(state_rd), .victim
    );

    l1_data_array data_inst (
        .clk, .rd_en, .rd_set, .wr_en(data_wr_en), .wr_set, .wr_way, .wr_data,
        .rd_data(data_rd)
    );

    l1_cdiff cdiff_inst (
        .clk, .reset, .tag_wr_en, .state_wr_en, .data_wr_en,
        .wr_set, .wr_way, .wr_tag, .wr_state, .wr_data, .wr_op,
        .diff_valid, .diff_ready, .diff, .diff_afull
    );

endmodule

`default_nettype wire

// File: l1_cdiff.sv
`default_nettype none

`include "l1_params.svh"

module l1_cdiff (
    input  logic                clk,
    input  logic                reset,
    input  logic                tag_wr_en,
    input  logic                state_wr_en,
    input  logic                data_wr_en,
    input  l1_pkg::t_l1_set     wr_set,
    input  l1_pkg::t_l1_way     wr_way,
    input  l1_pkg::t_l1_tag     wr_tag,
    input  l1_pkg::t_mesi       wr_state,
    input  l1_pkg::t_cl         wr_data,
    input  l1_pkg::t_req_op     wr_op,
    output logic                diff_valid,
    input  logic                diff_ready,
    output l1_pkg::t_diff_rec   diff,
    output logic                diff_afull
);

    localparam int PTR_W     = $clog2(`L1_DIFF_DEPTH);
    localparam int AFULL_LVL = `L1_DIFF_DEPTH - 3;  // two in flight plus one accepting

    l1_pkg::t_diff_rec  fifo_mem [`L1_DIFF_DEPTH];
    l1_pkg::t_diff_rec  new_rec;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               push;
    logic               pop;

    // any array write means the line changed
    assign push    = tag_wr_en || state_wr_en || data_wr_en;
    assign pop     = diff_valid && diff_ready;
    assign new_rec = '{set: wr_set, way: wr_way, tag: wr_tag, state: wr_state,
                       data: wr_data, op: wr_op};

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= new_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`L1_DIFF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`L1_DIFF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign diff_valid = (count != '0);
    assign diff       = fifo_mem[rd_ptr];  // head stays put until popped
    assign diff_afull = (count > AFULL_LVL);

endmodule

`default_nettype wire

// File: l1_mempipe.sv
`default_nettype none

`include "l1_params.svh"

module l1_mempipe (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 req_valid,
    output logic                                 req_ready,
    input  l1_pkg::t_mempipe_req                 req,
    output logic                                 resp_valid,
    output l1_pkg::t_mempipe_resp                resp,
    output logic                                 rd_en,
    output l1_pkg::t_l1_set                      rd_set,
    input  l1_pkg::t_l1_tag [`L1_NUM_WAYS-1:0]   tag_rd,
    input  l1_pkg::t_mesi   [`L1_NUM_WAYS-1:0]   state_rd,
    input  l1_pkg::t_cl     [`L1_NUM_WAYS-1:0]   data_rd,
    input  l1_pkg::t_l1_way                      victim,
    output logic                                 tag_wr_en,
    output logic                                 state_wr_en,
    output logic                                 data_wr_en,
    output logic                                 victim_upd,
    output l1_pkg::t_l1_set                      wr_set,
    output l1_pkg::t_l1_way                      wr_way,
    output l1_pkg::t_l1_tag                      wr_tag,
    output l1_pkg::t_mesi                        wr_state,
    output l1_pkg::t_cl                          wr_data,
    output l1_pkg::t_req_op                      wr_op,
    input  logic                                 diff_afull
);

    l1_pkg::t_mm_state                  mm_state;
    logic                               accept;
    logic                               set_hazard;
    logic                               mm1_valid;
    l1_pkg::t_mempipe_req               mm1_req;
    logic                               mm2_valid;
    l1_pkg::t_mempipe_req               mm2_req;
    l1_pkg::t_l1_tag [`L1_NUM_WAYS-1:0] mm2_tags;
    l1_pkg::t_mesi   [`L1_NUM_WAYS-1:0] mm2_states;
    l1_pkg::t_cl     [`L1_NUM_WAYS-1:0] mm2_data;
    l1_pkg::t_l1_way                    mm2_victim;
    logic [`L1_NUM_WAYS-1:0]            hit_ways;
    logic [`L1_NUM_WAYS-1:0]            inv_ways;
    logic                               hit;
    logic                               alloc;
    logic                               state_we;
    logic                               data_we;
    l1_pkg::t_l1_way                    hit_way;
    l1_pkg::t_l1_way                    alloc_way;
    l1_pkg::t_l1_way                    way_sel;
    l1_pkg::t_cl                        hit_data;
    l1_pkg::t_cl                        new_data;
    l1_pkg::t_mesi                      fill_state;
    l1_pkg::t_mesi                      new_state;

    // **************************************************
    // request acceptance
    // **************************************************

    assign rd_set     = l1_pkg::t_l1_set'(req.paddr);
    assign set_hazard = mm1_valid && (l1_pkg::t_l1_set'(mm1_req.paddr) == rd_set);
    assign req_ready  = (mm_state == l1_pkg::MM_RUN) && !set_hazard && !diff_afull;
    assign accept     = req_valid && req_ready;
    assign rd_en      = accept; // arrays read on the accepting edge

    // pipe comes up idle and starts taking requests the cycle after reset
    always_ff @(posedge clk) begin
        if (!reset) begin
            mm_state   <= l1_pkg::MM_IDLE;
            mm1_valid  <= 1'b0;
            mm2_valid  <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            mm_state   <= l1_pkg::MM_RUN;
            mm1_valid  <= accept;
            mm2_valid  <= mm1_valid;
            resp_valid <= mm2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mm1_req <= req;
        end
        if (mm1_valid) begin
            mm2_req    <= mm1_req;
            mm2_tags   <= tag_rd;
            mm2_states <= state_rd;
            mm2_data   <= data_rd;
            mm2_victim <= victim;
        end
        if (mm2_valid) begin
            resp.op      <= mm2_req.op;
            resp.hit     <= hit;
            resp.way     <= way_sel;
            resp.rd_data <= new_data;
        end
    end

    // **************************************************
    // mm2 lookup and update
    // **************************************************

    always_comb begin
        hit_ways  = '0;
        inv_ways  = '0;
        hit_way   = '0;
        alloc_way = mm2_victim;  // both valid, take the victim
        for (int w = `L1_NUM_WAYS - 1; w >= 0; w--) begin
            inv_ways[w] = (mm2_states[w] == l1_pkg::MESI_I);
            hit_ways[w] = !inv_ways[w] && (mm2_tags[w] == wr_tag);
            if (hit_ways[w]) begin
                hit_way = l1_pkg::t_l1_way'(w);
            end
            if (inv_ways[w]) begin
                alloc_way = l1_pkg::t_l1_way'(w); // lowest invalid way ends up here
            end
        end
    end

    assign hit      = |hit_ways;
    assign way_sel  = hit ? hit_way : alloc_way;
    assign hit_data = hit ? mm2_data[hit_way] : '0;

    always_comb begin
        if (mm2_req.fill_shared) begin
            fill_state = l1_pkg::MESI_S;
        end else begin
            fill_state = l1_pkg::MESI_E;
        end
        alloc     = 1'b0;
        state_we  = 1'b0;
        data_we   = 1'b0;
        new_state = mm2_states[way_sel];
        new_data  = hit_data;
        case (mm2_req.op)
            l1_pkg::OP_RD: begin
                if (!hit) begin
                    alloc     = 1'b1;
                    state_we  = 1'b1;
                    data_we   = 1'b1;
                    new_state = fill_state;
                    new_data  = mm2_req.fill_data;
                end
            end
            l1_pkg::OP_WR: begin
                alloc     = !hit;
                state_we  = 1'b1;
                data_we   = 1'b1;
                new_state = l1_pkg::MESI_M;
                new_data  = mm2_req.wr_data;
            end
            l1_pkg::OP_FILL: begin
                alloc     = !hit;
                state_we  = 1'b1;
                data_we   = 1'b1;
                new_state = fill_state;
                new_data  = mm2_req.fill_data;
            end
            l1_pkg::OP_INV: begin
                if (hit) begin
                    state_we  = 1'b1;  // tag and data stay
                    new_state = l1_pkg::MESI_I;
                end
            end
            default: begin
            end
        endcase
    end

    assign tag_wr_en   = mm2_valid && alloc;
    assign state_wr_en = mm2_valid && state_we;
    assign data_wr_en  = mm2_valid && data_we;
    assign victim_upd  = mm2_valid && alloc && !(|inv_ways);
    assign wr_set      = l1_pkg::t_l1_set'(mm2_req.paddr);
    assign wr_way      = way_sel;
    assign wr_tag      = l1_pkg::t_l1_tag'(mm2_req.paddr >> $bits(l1_pkg::t_l1_set));
    assign wr_state    = new_state;
    assign wr_data     = new_data;
    assign wr_op       = mm2_req.op;

endmodule

`default_nettype wire

// File: l1_data_array.sv
`default_nettype none

`include "l1_params.svh"

module l1_data_array (
    input  logic                               clk,
    input  logic                               rd_en,
    input  l1_pkg::t_l1_set                    rd_set,
    input  logic                               wr_en,
    input  l1_pkg::t_l1_set                    wr_set,
    input  l1_pkg::t_l1_way                    wr_way,
    input  l1_pkg::t_cl                        wr_data,
    output l1_pkg::t_cl [`L1_NUM_WAYS-1:0]     rd_data
);

    l1_pkg::t_cl [`L1_NUM_WAYS-1:0] data_mem [`L1_NUM_SETS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_set][wr_way] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= data_mem[rd_set];
            if (wr_en && (wr_set == rd_set)) begin
                rd_data[wr_way] <= wr_data; // write-through on a set collision
            end
        end
    end

endmodule

`default_nettype wire

// File: l1_state_array.sv
`default_nettype none

`include "l1_params.svh"

module l1_state_array (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 rd_en,
    input  l1_pkg::t_l1_set                      rd_set,
    input  logic                                 wr_en,
    input  l1_pkg::t_l1_set                      wr_set,
    input  l1_pkg::t_l1_way                      wr_way,
    input  l1_pkg::t_mesi                        wr_state,
    input  logic                                 victim_upd,
    output l1_pkg::t_mesi [`L1_NUM_WAYS-1:0]     rd_states,
    output l1_pkg::t_l1_way                      victim
);

    l1_pkg::t_mesi [`L1_NUM_WAYS-1:0] state_mem [`L1_NUM_SETS];
    logic [`L1_NUM_SETS-1:0]          victim_bits;  // one round-robin bit per set

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int s = 0; s < `L1_NUM_SETS; s++) begin
                for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                    state_mem[s][w] <= l1_pkg::MESI_I;
                end
            end
            victim_bits <= '0;
        end else begin
            if (wr_en) begin
                state_mem[wr_set][wr_way] <= wr_state;
            end
            if (victim_upd) begin
                victim_bits[wr_set] <= ~victim_bits[wr_set];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_states <= state_mem[rd_set];
            victim    <= victim_bits[rd_set] ^ (victim_upd && (wr_set == rd_set));
            if (wr_en && (wr_set == rd_set)) begin
                rd_states[wr_way] <= wr_state; // forward the same-edge write
            end
        end
    end

endmodule

`default_nettype wire

// File: l1_tag_array.sv
`default_nettype none

`include "l1_params.svh"

module l1_tag_array (
    input  logic                                 clk,
    input  logic                                 rd_en,
    input  l1_pkg::t_l1_set                      rd_set,
    input  logic                                 wr_en,
    input  l1_pkg::t_l1_set                      wr_set,
    input  l1_pkg::t_l1_way                      wr_way,
    input  l1_pkg::t_l1_tag                      wr_tag,
    output l1_pkg::t_l1_tag [`L1_NUM_WAYS-1:0]   rd_tags
);

    l1_pkg::t_l1_tag [`L1_NUM_WAYS-1:0] tag_mem [`L1_NUM_SETS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_set][wr_way] <= wr_tag;
        end
    end

    // both ways of the set come back together
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_tags <= tag_mem[rd_set];
            if (wr_en && (wr_set == rd_set)) begin
                rd_tags[wr_way] <= wr_tag; // write on the same edge is seen by the read
            end
        end
    end

endmodule

`default_nettype wire

// File: l1_pkg.sv
`default_nettype none

`include "l1_params.svh"

package l1_pkg;

    typedef logic [$clog2(`L1_NUM_SETS)-1:0]                  t_l1_set;
    typedef logic                                             t_l1_way;
    typedef logic [`L1_TAG_W-1:0]                             t_l1_tag;
    typedef logic [`L1_TAG_W+$clog2(`L1_NUM_SETS)-1:0]        t_paddr;  // {tag, set}
    typedef logic [`L1_DATA_W-1:0]                            t_cl;

    typedef enum logic [1:0] {
        MESI_I,
        MESI_S,
        MESI_E,
        MESI_M
    } t_mesi;

    typedef enum logic [1:0] {
        OP_RD,
        OP_WR,
        OP_FILL,
        OP_INV
    } t_req_op;

    typedef enum logic {
        MM_IDLE,
        MM_RUN
    } t_mm_state;

    typedef struct packed {
        t_req_op op;
        t_paddr  paddr;
        t_cl     wr_data;
        t_cl     fill_data;   // line contents supplied by the requester on a miss
        logic    fill_shared; // install as S instead of E
    } t_mempipe_req;

    typedef struct packed {
        t_req_op op;
        logic    hit;
        t_l1_way way;
        t_cl     rd_data;
    } t_mempipe_resp;

    // new image of one set/way after a change
    typedef struct packed {
        t_l1_set set;
        t_l1_way way;
        t_l1_tag tag;
        t_mesi   state;
        t_cl     data;
        t_req_op op;
    } t_diff_rec;

endpackage

`default_nettype wire

// File: l1_params.svh
`ifndef L1_PARAMS_SVH
`define L1_PARAMS_SVH

// **************************************************
// l1 data cache geometry
// **************************************************

// sets per way, index comes from the low address bits
`define L1_NUM_SETS 16

// associativity, the way index is a single bit
`define L1_NUM_WAYS 2

// address tag above the set index
`define L1_TAG_W 8

// one data word per line
`define L1_DATA_W 32

// **************************************************
// change log
// **************************************************

// must leave room for two requests in flight plus one
`define L1_DIFF_DEPTH 4

`endif
